// ==== compile.f ====
hw/icache_pkg.sv
hw/icache_line_store.sv
hw/icache_refill.sv
hw/icache_fetch_ctrl.sv
hw/icache_top.sv
sim/icache_checker.sv
sim/tb_icache.sv

// ==== hw/icache_fetch_ctrl.sv ====
// Fetch controller with tag compare, victim choice, flush sweep and fault detection
`timescale 1ns/1ps

module icache_fetch_ctrl import icache_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_valid_i,
  input  logic [FETCH_ADDR_LEN-1:0]           req_addr_i,
  input  logic                                req_flush_i,
  input  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  rd_tag_i,
  input  logic [NUM_WAYS-1:0]                 rd_valid_i,
  input  logic [NUM_WAYS-1:0][BEAT_WIDTH-1:0] rd_data_i,
  input  logic                                fill_done_i,
  input  logic                                fill_denied_i,
  output logic                                req_ready_o,
  output logic                                resp_valid_o,
  output logic [INSTR_WIDTH-1:0]              resp_instr_o,
  output logic                                resp_fault_o,
  output logic                                rd_req_o,
  output logic [SETS_WIDTH-1:0]               rd_set_o,
  output logic [BEATS_WIDTH-1:0]              rd_beat_o,
  output logic                                inv_req_o,
  output logic [SETS_WIDTH-1:0]               inv_set_o,
  output logic                                fill_start_o,
  output logic [LINE_ADDR_WIDTH-1:0]          fill_line_o,
  output logic [WAYS_WIDTH-1:0]               fill_way_o
);

  logic [CTRL_STATE_WIDTH-1:0] state_q, state_d;
  logic [SETS_WIDTH-1:0]       sweep_set_q, sweep_set_d;
  logic                        flush_pending_q, flush_pending_d;
  logic [WAYS_WIDTH-1:0]       rr_q, rr_d;
  logic [PHYS_ADDR_LEN-1:0]    addr_q;

  logic [NUM_WAYS-1:0]   hit;
  logic [WAYS_WIDTH-1:0] hit_way;
  logic [WAYS_WIDTH-1:0] victim_way;
  logic [BEAT_WIDTH-1:0] hit_data;

  wire req_fire  = req_valid_i && req_ready_o;
  wire req_fault = |req_addr_i[FETCH_ADDR_LEN-1:PHYS_ADDR_LEN];
  wire all_valid = &rd_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Tag compare and victim choice
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit        = '0;
    hit_way    = '0;
    victim_way = rr_q;
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (rd_valid_i[i] &&
          rd_tag_i[i] == addr_q[PHYS_ADDR_LEN-1:SETS_WIDTH+LINE_OFFSET_WIDTH]) begin
        hit[i]  = 1'b1;
        hit_way = WAYS_WIDTH'(i);
      end
      // Lowest invalid way wins
      if (!rd_valid_i[i]) victim_way = WAYS_WIDTH'(i);
    end
  end

  assign hit_data     = rd_data_i[hit_way];
  // Bit 2 picks the instruction within the beat
  assign resp_instr_o = addr_q[2] ? hit_data[BEAT_WIDTH-1:INSTR_WIDTH] : hit_data[INSTR_WIDTH-1:0];

  //////////////////////////////////////////////////////////////////////
  // Main FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    sweep_set_d     = sweep_set_q;
    flush_pending_d = flush_pending_q;
    rr_d            = rr_q;
    fill_start_o    = 1'b0;

    case (state_q)
      CTRL_SWEEP: begin
        sweep_set_d = sweep_set_q + SETS_WIDTH'(1);
        if (&sweep_set_q) begin
          // A flush resumes with its own fetch
          state_d         = flush_pending_q ? CTRL_REPLAY : CTRL_IDLE;
          flush_pending_d = 1'b0;
        end
      end
      CTRL_IDLE: begin
        if (req_valid_i) begin
          if (req_fault) begin
            state_d = CTRL_FAULT;
          end else if (req_flush_i) begin
            state_d         = CTRL_SWEEP;
            flush_pending_d = 1'b1;
          end else begin
            state_d = CTRL_LOOKUP;
          end
        end
      end
      CTRL_LOOKUP: begin
        if (|hit) begin
          state_d = CTRL_IDLE;
        end else begin
          fill_start_o = 1'b1;
          if (all_valid) rr_d = rr_q + WAYS_WIDTH'(1);
          state_d = CTRL_FILL;
        end
      end
      CTRL_FILL: begin
        if (fill_done_i) state_d = fill_denied_i ? CTRL_FAULT : CTRL_REPLAY;
      end
      CTRL_REPLAY: state_d = CTRL_LOOKUP;
      CTRL_FAULT:  state_d = CTRL_IDLE;
      default:     state_d = CTRL_SWEEP;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= CTRL_SWEEP;
      sweep_set_q     <= '0;
      flush_pending_q <= 1'b0;
      rr_q            <= '0;
    end else begin
      state_q         <= state_d;
      sweep_set_q     <= sweep_set_d;
      flush_pending_q <= flush_pending_d;
      rr_q            <= rr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) addr_q <= req_addr_i[PHYS_ADDR_LEN-1:0];
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign req_ready_o  = state_q == CTRL_IDLE;
  assign resp_valid_o = (state_q == CTRL_LOOKUP && |hit) || state_q == CTRL_FAULT;
  assign resp_fault_o = state_q == CTRL_FAULT;

  // New requests read straight from the port, replays from the latched address
  assign rd_req_o  = (req_fire && !req_fault && !req_flush_i) || state_q == CTRL_REPLAY;
  assign rd_set_o  = req_ready_o ? req_addr_i[LINE_OFFSET_WIDTH+:SETS_WIDTH]
                                 : addr_q[LINE_OFFSET_WIDTH+:SETS_WIDTH];
  assign rd_beat_o = req_ready_o ? req_addr_i[LINE_OFFSET_WIDTH-BEATS_WIDTH+:BEATS_WIDTH]
                                 : addr_q[LINE_OFFSET_WIDTH-BEATS_WIDTH+:BEATS_WIDTH];

  assign inv_req_o = state_q == CTRL_SWEEP;
  assign inv_set_o = sweep_set_q;

  assign fill_line_o = addr_q[PHYS_ADDR_LEN-1:LINE_OFFSET_WIDTH];
  assign fill_way_o  = victim_way;

endmodule

// ==== hw/icache_line_store.sv ====
// Line store holding per-way tags, valid bits and line data with read bypass
`timescale 1ns/1ps

module icache_line_store import icache_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   rd_req_i,
  input  logic [SETS_WIDTH-1:0]                  rd_set_i,
  input  logic [BEATS_WIDTH-1:0]                 rd_beat_i,
  input  logic [WAYS_WIDTH-1:0]                  wr_way_i,
  input  logic [SETS_WIDTH-1:0]                  wr_set_i,
  input  logic [BEATS_WIDTH-1:0]                 wr_beat_i,
  input  logic                                   wr_data_req_i,
  input  logic [BEAT_WIDTH-1:0]                  wr_data_i,
  input  logic                                   wr_tag_req_i,
  input  logic [TAG_WIDTH-1:0]                   wr_tag_i,
  input  logic                                   inv_req_i,
  input  logic [SETS_WIDTH-1:0]                  inv_set_i,
  output logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]     rd_tag_o,
  output logic [NUM_WAYS-1:0]                    rd_valid_o,
  output logic [NUM_WAYS-1:0][BEAT_WIDTH-1:0]    rd_data_o
);

  // Same-cycle write data, shared by all ways
  logic [TAG_WIDTH-1:0]  tag_bypass_q;
  logic [BEAT_WIDTH-1:0] data_bypass_q;

  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      tag_bypass_q  <= wr_tag_i;
      data_bypass_q <= wr_data_i;
    end
  end

  for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
    logic [TAG_WIDTH-1:0]  tag_mem [NUM_SETS];
    logic                  valid_mem [NUM_SETS];
    logic [BEAT_WIDTH-1:0] data_mem [NUM_SETS*BEATS_PER_LINE];

    logic [TAG_WIDTH-1:0]  tag_raw_q;
    logic                  valid_raw_q;
    logic [BEAT_WIDTH-1:0] data_raw_q;
    logic                  tag_byp_q;
    logic                  data_byp_q;

    wire way_sel = wr_way_i == WAYS_WIDTH'(i);

    // Array writes; refill and invalidate never overlap
    always_ff @(posedge clk_i) begin
      if (wr_tag_req_i && way_sel) begin
        tag_mem[wr_set_i]   <= wr_tag_i;
        valid_mem[wr_set_i] <= 1'b1;
      end
      if (inv_req_i) begin
        valid_mem[inv_set_i] <= 1'b0;
      end
      if (wr_data_req_i && way_sel) begin
        data_mem[{wr_set_i, wr_beat_i}] <= wr_data_i;
      end
    end

    // Synchronous read
    always_ff @(posedge clk_i) begin
      if (rd_req_i) begin
        tag_raw_q   <= tag_mem[rd_set_i];
        valid_raw_q <= valid_mem[rd_set_i] && !(inv_req_i && inv_set_i == rd_set_i);
        data_raw_q  <= data_mem[{rd_set_i, rd_beat_i}];
      end
    end

    // Bypass flags, set when a write hits the entry being read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tag_byp_q  <= 1'b0;
        data_byp_q <= 1'b0;
      end else if (rd_req_i) begin
        tag_byp_q  <= wr_tag_req_i && way_sel && wr_set_i == rd_set_i;
        data_byp_q <= wr_data_req_i && way_sel &&
                      {wr_set_i, wr_beat_i} == {rd_set_i, rd_beat_i};
      end
    end

    assign rd_tag_o[i]   = tag_byp_q ? tag_bypass_q : tag_raw_q;
    assign rd_valid_o[i] = tag_byp_q || valid_raw_q;
    assign rd_data_o[i]  = data_byp_q ? data_bypass_q : data_raw_q;
  end

endmodule

// ==== hw/icache_pkg.sv ====
// Instruction cache package with the cache geometry and the FSM state encodings
package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned WAYS_WIDTH     = 1;
  localparam int unsigned NUM_WAYS       = 1 << WAYS_WIDTH;
  localparam int unsigned SETS_WIDTH     = 4;
  localparam int unsigned NUM_SETS       = 1 << SETS_WIDTH;
  localparam int unsigned BEATS_WIDTH    = 3;
  localparam int unsigned BEATS_PER_LINE = 1 << BEATS_WIDTH;

  // 64-byte lines
  localparam int unsigned LINE_OFFSET_WIDTH = 6;

  // Address widths
  localparam int unsigned PHYS_ADDR_LEN   = 32;
  localparam int unsigned FETCH_ADDR_LEN  = 64;
  localparam int unsigned TAG_WIDTH       = PHYS_ADDR_LEN - SETS_WIDTH - LINE_OFFSET_WIDTH;
  localparam int unsigned LINE_ADDR_WIDTH = PHYS_ADDR_LEN - LINE_OFFSET_WIDTH;

  // Data widths
  localparam int unsigned BEAT_WIDTH  = 64;
  localparam int unsigned INSTR_WIDTH = 32;

  //////////////////////////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////////////////////////

  // Refill engine
  localparam int unsigned REFILL_STATE_WIDTH = 2;
  localparam logic [REFILL_STATE_WIDTH-1:0] REFILL_IDLE  = 2'd0;
  localparam logic [REFILL_STATE_WIDTH-1:0] REFILL_REQ   = 2'd1;
  localparam logic [REFILL_STATE_WIDTH-1:0] REFILL_BEATS = 2'd2;

  // Fetch controller
  localparam int unsigned CTRL_STATE_WIDTH = 3;
  localparam logic [CTRL_STATE_WIDTH-1:0] CTRL_SWEEP  = 3'd0;
  localparam logic [CTRL_STATE_WIDTH-1:0] CTRL_IDLE   = 3'd1;
  localparam logic [CTRL_STATE_WIDTH-1:0] CTRL_LOOKUP = 3'd2;
  localparam logic [CTRL_STATE_WIDTH-1:0] CTRL_FILL   = 3'd3;
  localparam logic [CTRL_STATE_WIDTH-1:0] CTRL_REPLAY = 3'd4;
  localparam logic [CTRL_STATE_WIDTH-1:0] CTRL_FAULT  = 3'd5;

endpackage

// ==== hw/icache_refill.sv ====
// Refill engine that requests a line from memory and writes its beats into the line store
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fill_start_i,
  input  logic [LINE_ADDR_WIDTH-1:0] fill_line_i,
  input  logic [WAYS_WIDTH-1:0]      fill_way_i,
  input  logic                       mem_req_ready_i,
  input  logic                       mem_gnt_valid_i,
  input  logic [BEAT_WIDTH-1:0]      mem_gnt_data_i,
  input  logic                       mem_gnt_denied_i,
  output logic                       mem_req_valid_o,
  output logic [LINE_ADDR_WIDTH-1:0] mem_req_line_o,
  output logic                       mem_gnt_ready_o,
  output logic [WAYS_WIDTH-1:0]      wr_way_o,
  output logic [SETS_WIDTH-1:0]      wr_set_o,
  output logic [BEATS_WIDTH-1:0]     wr_beat_o,
  output logic                       wr_data_req_o,
  output logic [BEAT_WIDTH-1:0]      wr_data_o,
  output logic                       wr_tag_req_o,
  output logic [TAG_WIDTH-1:0]       wr_tag_o,
  output logic                       fill_done_o,
  output logic                       fill_denied_o
);

  logic [REFILL_STATE_WIDTH-1:0] state_q;
  logic [BEATS_WIDTH-1:0]        beat_q;
  logic                          denied_q;
  logic [LINE_ADDR_WIDTH-1:0]    line_q;
  logic [WAYS_WIDTH-1:0]         way_q;

  wire gnt_fire  = mem_gnt_valid_i && mem_gnt_ready_o;
  wire last_beat = &beat_q;

  // Line address and target way of the current refill
  always_ff @(posedge clk_i) begin
    if (state_q == REFILL_IDLE && fill_start_i) begin
      line_q <= fill_line_i;
      way_q  <= fill_way_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= REFILL_IDLE;
      beat_q   <= '0;
      denied_q <= 1'b0;
    end else begin
      case (state_q)
        REFILL_IDLE: begin
          if (fill_start_i) begin
            state_q  <= REFILL_REQ;
            beat_q   <= '0;
            denied_q <= 1'b0;
          end
        end
        REFILL_REQ: begin
          if (mem_req_ready_i) state_q <= REFILL_BEATS;
        end
        REFILL_BEATS: begin
          if (gnt_fire) begin
            beat_q   <= beat_q + BEATS_WIDTH'(1);
            denied_q <= denied_q || mem_gnt_denied_i;
            if (last_beat) state_q <= REFILL_IDLE;
          end
        end
        default: state_q <= REFILL_IDLE;
      endcase
    end
  end

  assign mem_req_valid_o = state_q == REFILL_REQ;
  assign mem_req_line_o  = line_q;
  assign mem_gnt_ready_o = state_q == REFILL_BEATS;

  // Beats go straight into the data array; tag and valid follow the last one
  assign wr_way_o      = way_q;
  assign wr_set_o      = line_q[SETS_WIDTH-1:0];
  assign wr_beat_o     = beat_q;
  assign wr_data_req_o = gnt_fire && !mem_gnt_denied_i;
  assign wr_data_o     = mem_gnt_data_i;
  assign wr_tag_req_o  = gnt_fire && last_beat && !mem_gnt_denied_i && !denied_q;
  assign wr_tag_o      = line_q[LINE_ADDR_WIDTH-1:SETS_WIDTH];

  assign fill_done_o   = gnt_fire && last_beat;
  assign fill_denied_o = denied_q || mem_gnt_denied_i;

endmodule

// ==== hw/icache_top.sv ====
// Instruction cache top level joining fetch controller, line store and refill engine
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // CPU side
  input  logic                       req_valid_i,
  input  logic [FETCH_ADDR_LEN-1:0]  req_addr_i,
  input  logic                       req_flush_i,
  output logic                       req_ready_o,
  output logic                       resp_valid_o,
  output logic [INSTR_WIDTH-1:0]     resp_instr_o,
  output logic                       resp_fault_o,
  // Memory side
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output logic [LINE_ADDR_WIDTH-1:0] mem_req_line_o,
  input  logic                       mem_gnt_valid_i,
  output logic                       mem_gnt_ready_o,
  input  logic [BEAT_WIDTH-1:0]      mem_gnt_data_i,
  input  logic                       mem_gnt_denied_i
);

  // Line store read and invalidate
  logic                                rd_req;
  logic [SETS_WIDTH-1:0]               rd_set;
  logic [BEATS_WIDTH-1:0]              rd_beat;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  rd_tag;
  logic [NUM_WAYS-1:0]                 rd_valid;
  logic [NUM_WAYS-1:0][BEAT_WIDTH-1:0] rd_data;
  logic                                inv_req;
  logic [SETS_WIDTH-1:0]               inv_set;

  // Refill writes
  logic [WAYS_WIDTH-1:0]  wr_way;
  logic [SETS_WIDTH-1:0]  wr_set;
  logic [BEATS_WIDTH-1:0] wr_beat;
  logic                   wr_data_req;
  logic [BEAT_WIDTH-1:0]  wr_data;
  logic                   wr_tag_req;
  logic [TAG_WIDTH-1:0]   wr_tag;

  // Controller to refill handoff
  logic                       fill_start;
  logic [LINE_ADDR_WIDTH-1:0] fill_line;
  logic [WAYS_WIDTH-1:0]      fill_way;
  logic                       fill_done;
  logic                       fill_denied;

  icache_fetch_ctrl u_fetch_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_flush_i   (req_flush_i),
    .rd_tag_i      (rd_tag),
    .rd_valid_i    (rd_valid),
    .rd_data_i     (rd_data),
    .fill_done_i   (fill_done),
    .fill_denied_i (fill_denied),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_instr_o  (resp_instr_o),
    .resp_fault_o  (resp_fault_o),
    .rd_req_o      (rd_req),
    .rd_set_o      (rd_set),
    .rd_beat_o     (rd_beat),
    .inv_req_o     (inv_req),
    .inv_set_o     (inv_set),
    .fill_start_o  (fill_start),
    .fill_line_o   (fill_line),
    .fill_way_o    (fill_way)
  );

  icache_line_store u_line_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req),
    .rd_set_i      (rd_set),
    .rd_beat_i     (rd_beat),
    .wr_way_i      (wr_way),
    .wr_set_i      (wr_set),
    .wr_beat_i     (wr_beat),
    .wr_data_req_i (wr_data_req),
    .wr_data_i     (wr_data),
    .wr_tag_req_i  (wr_tag_req),
    .wr_tag_i      (wr_tag),
    .inv_req_i     (inv_req),
    .inv_set_i     (inv_set),
    .rd_tag_o      (rd_tag),
    .rd_valid_o    (rd_valid),
    .rd_data_o     (rd_data)
  );

  icache_refill u_refill (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fill_start_i     (fill_start),
    .fill_line_i      (fill_line),
    .fill_way_i       (fill_way),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_gnt_valid_i  (mem_gnt_valid_i),
    .mem_gnt_data_i   (mem_gnt_data_i),
    .mem_gnt_denied_i (mem_gnt_denied_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_line_o   (mem_req_line_o),
    .mem_gnt_ready_o  (mem_gnt_ready_o),
    .wr_way_o         (wr_way),
    .wr_set_o         (wr_set),
    .wr_beat_o        (wr_beat),
    .wr_data_req_o    (wr_data_req),
    .wr_data_o        (wr_data),
    .wr_tag_req_o     (wr_tag_req),
    .wr_tag_o         (wr_tag),
    .fill_done_o      (fill_done),
    .fill_denied_o    (fill_denied)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the instruction cache testbench with Verilator and run it.
# The run counts as good only if the output holds the pass message.

cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --top-module tb_icache \
       --Mdir obj_dir -f compile.f \
  && ./obj_dir/Vtb_icache | tee /dev/stderr | grep -q "^Test passed$" \
  && echo "run.sh: simulation OK" \
  || { echo "run.sh: simulation FAILED"; exit 1; }

// ==== sim/icache_checker.sv ====
// Instruction cache scoreboard with tag, replacement and memory models
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; #(
  parameter logic [LINE_ADDR_WIDTH-1:0] DENIED_LINE = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_valid_i,
  input  logic                       req_ready_i,
  input  logic [FETCH_ADDR_LEN-1:0]  req_addr_i,
  input  logic                       req_flush_i,
  input  logic                       resp_valid_i,
  input  logic [INSTR_WIDTH-1:0]     resp_instr_i,
  input  logic                       resp_fault_i,
  input  logic                       mem_req_valid_i,
  input  logic                       mem_req_ready_i,
  input  logic [LINE_ADDR_WIDTH-1:0] mem_req_line_i,
  input  logic                       mem_gnt_valid_i,
  input  logic                       mem_gnt_ready_i,
  output int unsigned                tests_o,
  output int unsigned                errors_o
);

  logic [TAG_WIDTH-1:0]       tag_m [NUM_SETS][NUM_WAYS];
  logic                       valid_m [NUM_SETS][NUM_WAYS];
  logic [WAYS_WIDTH-1:0]      rr_m;
  logic                       pending;
  logic                       test_ok;
  logic [FETCH_ADDR_LEN-1:0]  exp_addr;
  logic                       exp_fault;
  logic [INSTR_WIDTH-1:0]     exp_instr;
  logic [LINE_ADDR_WIDTH-1:0] exp_line;
  int unsigned                exp_reqs;
  int unsigned                seen_reqs;
  logic                       refill_active;
  int unsigned                beats_seen;
  string                      kind;

  // Memory contents as a hash of the beat's byte address
  function automatic logic [BEAT_WIDTH-1:0] expected_beat(input logic [PHYS_ADDR_LEN-1:0] a);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = (a * 32'h9e37_79b9) ^ 32'h1234_5678;
    hi = (a ^ 32'hc3a5_f00f) * 32'h85eb_ca6b;
    return {hi, lo};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    test_ok  = 1'b0;
    errors_o = errors_o + 1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Expected outcome of an accepted fetch and the model update
  //////////////////////////////////////////////////////////////////////

  task automatic predict(input logic [FETCH_ADDR_LEN-1:0] addr, input logic flush);
    logic [SETS_WIDTH-1:0] set_idx;
    logic [TAG_WIDTH-1:0]  tag;
    logic [BEAT_WIDTH-1:0] beat;
    logic                  hit;
    logic                  found;
    logic [WAYS_WIDTH-1:0] victim;
    set_idx   = addr[LINE_OFFSET_WIDTH+:SETS_WIDTH];
    tag       = addr[PHYS_ADDR_LEN-1:SETS_WIDTH+LINE_OFFSET_WIDTH];
    beat      = expected_beat({addr[PHYS_ADDR_LEN-1:3], 3'b000});
    exp_addr  = addr;
    exp_instr = addr[2] ? beat[BEAT_WIDTH-1:INSTR_WIDTH] : beat[INSTR_WIDTH-1:0];
    exp_line  = addr[PHYS_ADDR_LEN-1:LINE_OFFSET_WIDTH];
    exp_fault = 1'b0;
    exp_reqs  = 0;
    seen_reqs = 0;
    pending   = 1'b1;
    test_ok   = 1'b1;
    hit       = 1'b0;
    found     = 1'b0;
    victim    = rr_m;
    if (|addr[FETCH_ADDR_LEN-1:PHYS_ADDR_LEN]) begin
      kind      = "fault";
      exp_fault = 1'b1;
    end else begin
      if (flush) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          for (int w = 0; w < NUM_WAYS; w++) valid_m[s][w] = 1'b0;
        end
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (valid_m[set_idx][w] && tag_m[set_idx][w] == tag) hit = 1'b1;
      end
      if (hit) begin
        kind = "hit";
      end else begin
        exp_reqs = 1;
        // First invalid way, else the shared round-robin pointer
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (!found && !valid_m[set_idx][w]) begin
            victim = WAYS_WIDTH'(w);
            found  = 1'b1;
          end
        end
        if (!found) rr_m = rr_m + WAYS_WIDTH'(1);
        if (exp_line == DENIED_LINE) begin
          kind      = "denied";
          exp_fault = 1'b1;
        end else begin
          kind                    = "miss";
          tag_m[set_idx][victim]   = tag;
          valid_m[set_idx][victim] = 1'b1;
        end
      end
      if (flush) kind = {"flush ", kind};
    end
  endtask

  task automatic finish_test();
    if (resp_fault_i !== exp_fault) begin
      report_mismatch($sformatf("fault bit %b, expected %b (addr %h)",
                                resp_fault_i, exp_fault, exp_addr));
    end else if (!exp_fault && resp_instr_i !== exp_instr) begin
      report_mismatch($sformatf("instr %h, expected %h (addr %h)",
                                resp_instr_i, exp_instr, exp_addr));
    end
    if (seen_reqs != exp_reqs) begin
      report_mismatch($sformatf("%0d memory requests, expected %0d (addr %h)",
                                seen_reqs, exp_reqs, exp_addr));
    end
    $display("test %0d: %s, addr %h, %s", tests_o, kind, exp_addr,
             test_ok ? "ok" : "mismatch");
    tests_o = tests_o + 1;
    pending = 1'b0;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) valid_m[s][w] = 1'b0;
      end
      rr_m          = '0;
      pending       = 1'b0;
      seen_reqs     = 0;
      refill_active = 1'b0;
      beats_seen    = 0;
      tests_o       = 0;
      errors_o      = 0;
    end else begin
      // One fetch in flight at a time
      if (req_ready_i && pending) begin
        report_mismatch($sformatf("ready high while fetch of %h is in flight", exp_addr));
      end
      // Grant ready covers the eight beats of a refill and nothing else
      if (mem_gnt_ready_i !== refill_active) begin
        report_mismatch($sformatf("grant ready %b, expected %b",
                                  mem_gnt_ready_i, refill_active));
      end
      if (mem_gnt_valid_i && mem_gnt_ready_i && refill_active) begin
        beats_seen = beats_seen + 1;
        if (beats_seen == BEATS_PER_LINE) refill_active = 1'b0;
      end
      if (mem_req_valid_i && mem_req_ready_i) begin
        seen_reqs     = seen_reqs + 1;
        refill_active = 1'b1;
        beats_seen    = 0;
        if (!pending || exp_reqs == 0) begin
          $display("Memory request for line %h at %0t ns while no miss was outstanding",
                   mem_req_line_i, $time);
          errors_o = errors_o + 1;
        end else if (mem_req_line_i !== exp_line) begin
          report_mismatch($sformatf("request line %h, expected %h",
                                    mem_req_line_i, exp_line));
        end
      end
      if (resp_valid_i) begin
        if (pending) begin
          finish_test();
        end else begin
          $display("Response at %0t ns while no fetch was in flight", $time);
          errors_o = errors_o + 1;
        end
      end
      if (req_valid_i && req_ready_i) predict(req_addr_i, req_flush_i);
    end
  end

endmodule

// ==== sim/tb_icache.sv ====
// Instruction cache testbench with LCG fetch stimulus and a line refill memory
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  localparam int unsigned NUM_TESTS   = 400;
  // Flush sweep, request wait, eight beats with gaps, replay and stimulus gap
  localparam int unsigned MISS_CYCLES = 64;
  localparam int unsigned MAX_CYCLES  = NUM_TESTS * MISS_CYCLES + NUM_SETS + 16;
  localparam logic [31:0] SEED        = 32'hb6ca_9c1d;
  localparam logic [LINE_ADDR_WIDTH-1:0] DENIED_LINE = {22'h0beef, 4'h9};

  logic                       clk_i;
  logic                       rst_ni;
  logic                       req_valid_i;
  logic [FETCH_ADDR_LEN-1:0]  req_addr_i;
  logic                       req_flush_i;
  logic                       req_ready_o;
  logic                       resp_valid_o;
  logic [INSTR_WIDTH-1:0]     resp_instr_o;
  logic                       resp_fault_o;
  logic                       mem_req_valid_o;
  logic                       mem_req_ready_i;
  logic [LINE_ADDR_WIDTH-1:0] mem_req_line_o;
  logic                       mem_gnt_valid_i;
  logic                       mem_gnt_ready_o;
  logic [BEAT_WIDTH-1:0]      mem_gnt_data_i;
  logic                       mem_gnt_denied_i;
  int unsigned                tests;
  int unsigned                errors;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [BEAT_WIDTH-1:0] beat_hash(input logic [PHYS_ADDR_LEN-1:0] a);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = (a * 32'h9e37_79b9) ^ 32'h1234_5678;
    hi = (a ^ 32'hc3a5_f00f) * 32'h85eb_ca6b;
    return {hi, lo};
  endfunction

  // Six lines with three in set 3 and three in set 9
  function automatic logic [LINE_ADDR_WIDTH-1:0] pool_line(input logic [2:0] idx);
    case (idx)
      3'd0:    return {22'h00100, 4'h3};
      3'd1:    return {22'h02a51, 4'h3};
      3'd2:    return {22'h13f70, 4'h3};
      3'd3:    return {22'h00055, 4'h9};
      3'd4:    return {22'h1c0e2, 4'h9};
      default: return DENIED_LINE;
    endcase
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  icache_top u_icache_top (.*);

  icache_checker #(.DENIED_LINE(DENIED_LINE)) u_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .req_flush_i     (req_flush_i),
    .resp_valid_i    (resp_valid_o),
    .resp_instr_i    (resp_instr_o),
    .resp_fault_i    (resp_fault_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_line_i  (mem_req_line_o),
    .mem_gnt_valid_i (mem_gnt_valid_i),
    .mem_gnt_ready_i (mem_gnt_ready_o),
    .tests_o         (tests),
    .errors_o        (errors)
  );

  //////////////////////////////////////////////////////////////////////
  // Fetch stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0]               stim_state;
    logic [FETCH_ADDR_LEN-1:0] addr;
    logic                      flush;
    stim_state = SEED;
    rst_ni      <= 1'b0;
    req_valid_i <= 1'b0;
    req_addr_i  <= '0;
    req_flush_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      stim_state = lcg_next(stim_state);
      repeat (32'(stim_state[31:30])) @(posedge clk_i);
      stim_state = lcg_next(stim_state);
      addr  = {32'h0, pool_line(3'(stim_state[31:16] % 16'd6)), stim_state[15:12], 2'b00};
      flush = stim_state[11:8] == 4'd0;
      // Roughly one fetch in sixteen goes above the physical range
      if (stim_state[7:4] == 4'd0) begin
        addr[FETCH_ADDR_LEN-1:PHYS_ADDR_LEN] = 32'h1 << stim_state[3:0];
        flush = 1'b0;
      end
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_addr_i  <= addr;
      req_flush_i <= flush;
      @(posedge clk_i);
      while (!req_ready_o) @(posedge clk_i);
      req_valid_i <= 1'b0;
      req_flush_i <= 1'b0;
      @(posedge clk_i);
      while (!resp_valid_o) @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("%0d of %0d tests run, %0d errors", tests, NUM_TESTS, errors);
    if (errors == 0 && tests == NUM_TESTS) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory responder
  //////////////////////////////////////////////////////////////////////

  initial begin : memory_responder
    logic [31:0]                mem_state;
    logic [LINE_ADDR_WIDTH-1:0] line;
    logic                       denied;
    mem_state = SEED ^ 32'h0f0f_f0f0;
    mem_req_ready_i  <= 1'b0;
    mem_gnt_valid_i  <= 1'b0;
    mem_gnt_data_i   <= '0;
    mem_gnt_denied_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_valid_o) begin
        line      = mem_req_line_o;
        denied    = line == DENIED_LINE;
        mem_state = lcg_next(mem_state);
        repeat (32'(mem_state[31:30])) @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        @(posedge clk_i);
        mem_req_ready_i <= 1'b0;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
          mem_state = lcg_next(mem_state);
          if (32'(mem_state[31:30]) % 3 != 0) begin
            mem_gnt_valid_i <= 1'b0;
            repeat (32'(mem_state[31:30]) % 3) @(posedge clk_i);
          end
          mem_gnt_valid_i  <= 1'b1;
          mem_gnt_data_i   <= beat_hash({line, 3'(b), 3'b000});
          mem_gnt_denied_i <= denied;
          @(posedge clk_i);
          while (!mem_gnt_ready_o) @(posedge clk_i);
        end
        mem_gnt_valid_i  <= 1'b0;
        mem_gnt_denied_i <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles = cycles + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
